//--- common/mem_pkg.sv
package mem_pkg;

    localparam int xlen        = 32;
    localparam int lanes       = xlen / 8;        // bytes per word
    localparam int offset_bits = $clog2(lanes);   // byte offset inside a word

    // reference encoding of the 3-bit access mode
    typedef enum logic [2:0] {
        mode_none   = 3'd0,
        mode_word   = 3'd1,
        mode_half   = 3'd2,
        mode_byte   = 3'd3,
        mode_half_u = 3'd4,
        mode_byte_u = 3'd5
    } mem_mode_e;

    typedef enum logic [2:0] {
        res_alu = 3'd0,
        res_mem = 3'd1,
        res_pc4 = 3'd2,
        res_imm = 3'd3
    } result_src_e;

    // only the signed encodings double as store modes
    function automatic logic is_store(input mem_mode_e mode);
        return (mode == mode_word) || (mode == mode_half) || (mode == mode_byte);
    endfunction

    function automatic logic is_half(input mem_mode_e mode);
        return (mode == mode_half) || (mode == mode_half_u);
    endfunction

    function automatic logic is_byte(input mem_mode_e mode);
        return (mode == mode_byte) || (mode == mode_byte_u);
    endfunction

endpackage

//--- lsu/access_decode.sv
`timescale 1ns/1ps

module access_decode import mem_pkg::*; (
    input  mem_mode_e              mode,
    input  logic [offset_bits-1:0] offset,
    input  logic                   we,
    input  logic [xlen-1:0]        write_data,
    output logic [lanes-1:0]       byte_en,
    output logic [xlen-1:0]        wdata_lanes,
    output logic                   misaligned
);

    logic [lanes-1:0] lane_mask;    // lanes an aligned access covers
    logic             store_ok;

    // natural alignment, bytes always pass
    always_comb begin
        misaligned = 1'b0;
        if (mode == mode_word) begin
            misaligned = (offset != '0);
        end else if (is_half(mode)) begin
            misaligned = offset[0];
        end
    end

    // byte_en[3] is offset 0, big-endian
    always_comb begin
        lane_mask = '0;
        if (mode == mode_word) begin
            lane_mask = 4'b1111;
        end else if (is_half(mode)) begin
            lane_mask = offset[1] ? 4'b0011 : 4'b1100;  // upper byte at the lower offset
        end else if (is_byte(mode)) begin
            lane_mask = 4'b1000 >> offset;
        end
    end

    // data copied into every lane, byte_en picks the live ones
    always_comb begin
        case (mode)
            mode_half: begin
                wdata_lanes = {2{write_data[15:0]}};
            end
            mode_byte: begin
                wdata_lanes = {lanes{write_data[7:0]}};
            end
            default: begin
                wdata_lanes = write_data;
            end
        endcase
    end

    assign store_ok = we && is_store(mode) && !misaligned;
    assign byte_en  = store_ok ? lane_mask : '0;

endmodule

//--- lsu/load_extend.sv
`timescale 1ns/1ps

module load_extend import mem_pkg::*; (
    input  mem_mode_e              mode,
    input  logic [offset_bits-1:0] offset,
    input  logic                   misaligned,
    input  logic [xlen-1:0]        rdata_word,
    output logic [xlen-1:0]        load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // offset 0 sits in the top byte
    always_comb begin
        case (offset)
            2'd0: begin
                sel_byte = rdata_word[31:24];
            end
            2'd1: begin
                sel_byte = rdata_word[23:16];
            end
            2'd2: begin
                sel_byte = rdata_word[15:8];
            end
            default: begin
                sel_byte = rdata_word[7:0];
            end
        endcase
    end

    // only even offsets reach here for halves
    assign sel_half = offset[1] ? rdata_word[15:0] : rdata_word[31:16];

    always_comb begin
        load_data = '0;
        if (!misaligned) begin
            case (mode)
                mode_word: begin
                    load_data = rdata_word;
                end
                mode_half: begin
                    load_data = {{(xlen-16){sel_half[15]}}, sel_half};
                end
                mode_byte: begin
                    load_data = {{(xlen-8){sel_byte[7]}}, sel_byte};
                end
                mode_half_u: begin
                    load_data = {{(xlen-16){1'b0}}, sel_half};
                end
                mode_byte_u: begin
                    load_data = {{(xlen-8){1'b0}}, sel_byte};
                end
                default: begin
                    load_data = '0;         // mode_none and unused codes
                end
            endcase
        end
    end

endmodule

//--- data_mem/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_pkg::*; #(
    parameter int addr_bits = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [addr_bits-1:0] word_addr,
    input  logic [lanes-1:0]     byte_en,
    input  logic [xlen-1:0]      wdata_lanes,
    output logic [xlen-1:0]      rdata_word
);

    localparam int depth = 2 ** addr_bits;

    logic [xlen-1:0] mem [depth];   // contents survive reset

    // each lane written on its own enable
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < lanes; i++) begin
                if (byte_en[i]) begin
                    mem[word_addr][8*i +: 8] <= wdata_lanes[8*i +: 8];
                end
            end
        end
    end

    assign rdata_word = mem[word_addr];    // async read

endmodule

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import mem_pkg::*; #(
    parameter int addr_bits = 10
) (
    input  logic            clk,
    input  logic            rst,
    input  result_src_e     result_src,
    input  mem_mode_e       mem_mode,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] write_data,
    input  logic            we,
    input  logic [xlen-1:0] pc_plus4,
    input  logic [xlen-1:0] imm_ext,
    output logic [xlen-1:0] result,
    output logic            misaligned
);

    logic [addr_bits-1:0]   word_addr;
    logic [offset_bits-1:0] offset;
    logic [lanes-1:0]       byte_en;
    logic [xlen-1:0]        wdata_lanes;
    logic [xlen-1:0]        rdata_word;
    logic [xlen-1:0]        load_data;

    // alu_result is the byte address, high bits dropped so it wraps
    assign offset    = alu_result[offset_bits-1:0];
    assign word_addr = alu_result[addr_bits+offset_bits-1:offset_bits];

    access_decode i_access_decode (
        .mode        (mem_mode),
        .offset      (offset),
        .we          (we),
        .write_data  (write_data),
        .byte_en     (byte_en),
        .wdata_lanes (wdata_lanes),
        .misaligned  (misaligned)
    );

    data_ram #(
        .addr_bits (addr_bits)
    ) i_data_ram (
        .clk         (clk),
        .rst         (rst),
        .word_addr   (word_addr),
        .byte_en     (byte_en),
        .wdata_lanes (wdata_lanes),
        .rdata_word  (rdata_word)
    );

    load_extend i_load_extend (
        .mode       (mem_mode),
        .offset     (offset),
        .misaligned (misaligned),
        .rdata_word (rdata_word),
        .load_data  (load_data)
    );

    // write-back select
    always_comb begin
        case (result_src)
            res_alu: begin
                result = alu_result;
            end
            res_mem: begin
                result = load_data;
            end
            res_pc4: begin
                result = pc_plus4;
            end
            res_imm: begin
                result = imm_ext;
            end
            default: begin
                result = '0;    // unused source codes
            end
        endcase
    end

endmodule

//--- testbench/mem_wb_stage_properties.sv
`timescale 1ns/1ps

module mem_wb_stage_properties import mem_pkg::*; #(
    parameter int addr_bits = 10
) (
    input logic            clk,
    input logic            rst,
    input result_src_e     result_src,
    input mem_mode_e       mem_mode,
    input logic [xlen-1:0] alu_result,
    input logic [xlen-1:0] write_data,
    input logic            we,
    input logic [xlen-1:0] pc_plus4,
    input logic [xlen-1:0] imm_ext,
    input logic [xlen-1:0] result,
    input logic            misaligned
);

    localparam int nbytes = 4 * (2 ** addr_bits);

    logic [7:0]           shadow [nbytes];   // one entry per byte address
    bit                   known  [nbytes];   // byte written since start
    logic [addr_bits-1:0] widx;
    logic [1:0]           off;
    logic                 exp_mis;
    logic                 load_known;
    logic [xlen-1:0]      exp_load;
    logic [xlen-1:0]      exp_result;
    int                   err_count = 0;

    assign widx    = alu_result[addr_bits+1:2];
    assign off     = alu_result[1:0];
    assign exp_mis = (mem_mode == mode_word && off != 2'd0)
                  || ((mem_mode == mode_half || mem_mode == mode_half_u) && off[0]);

    // stores land big-endian, offset 0 takes the top byte
    always_ff @(posedge clk) begin
        if (!rst && we && !exp_mis) begin
            case (mem_mode)
                mode_word: begin
                    for (int k = 0; k < 4; k++) begin
                        shadow[{widx, k[1:0]}] <= write_data[31-8*k -: 8];
                        known[{widx, k[1:0]}]  <= 1'b1;
                    end
                end
                mode_half: begin
                    shadow[{widx, off}]         <= write_data[15:8];
                    shadow[{widx, off | 2'd1}]  <= write_data[7:0];
                    known[{widx, off}]          <= 1'b1;
                    known[{widx, off | 2'd1}]   <= 1'b1;
                end
                mode_byte: begin
                    shadow[{widx, off}] <= write_data[7:0];
                    known[{widx, off}]  <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        exp_load   = '0;
        load_known = 1'b1;
        if (!exp_mis) begin
            case (mem_mode)
                mode_word: begin
                    exp_load   = {shadow[{widx, 2'd0}], shadow[{widx, 2'd1}],
                                  shadow[{widx, 2'd2}], shadow[{widx, 2'd3}]};
                    load_known = known[{widx, 2'd0}] && known[{widx, 2'd1}]
                              && known[{widx, 2'd2}] && known[{widx, 2'd3}];
                end
                mode_half, mode_half_u: begin
                    exp_load[15:0] = {shadow[{widx, off}], shadow[{widx, off | 2'd1}]};
                    if (mem_mode == mode_half && exp_load[15]) begin
                        exp_load[31:16] = 16'hffff;
                    end
                    load_known = known[{widx, off}] && known[{widx, off | 2'd1}];
                end
                mode_byte, mode_byte_u: begin
                    exp_load[7:0] = shadow[{widx, off}];
                    if (mem_mode == mode_byte && exp_load[7]) begin
                        exp_load[31:8] = 24'hffffff;
                    end
                    load_known = known[{widx, off}];
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (result_src)
            res_alu: exp_result = alu_result;
            res_mem: exp_result = exp_load;
            res_pc4: exp_result = pc_plus4;
            res_imm: exp_result = imm_ext;
            default: exp_result = '0;
        endcase
    end

    // checked mid-cycle, inputs change on the rising edge
    misaligned_flag: assert property (@(negedge clk) misaligned == exp_mis)
        else begin
            err_count++;
            $error("CHECK FAILED at %0t: misaligned = %b, expected %b",
                   $time, misaligned, exp_mis);
        end

    result_select: assert property (@(negedge clk)
        result_src != res_mem |-> result == exp_result)
        else begin
            err_count++;
            $error("CHECK FAILED at %0t: result = %h, expected %h", $time, result, exp_result);
        end

    load_value: assert property (@(negedge clk)
        (result_src == res_mem && load_known) |-> result == exp_result)
        else begin
            err_count++;
            $error("CHECK FAILED at %0t: result = %h, expected %h", $time, result, exp_result);
        end

endmodule

//--- testbench/mem_wb_stage_tb.sv
`timescale 1ns/1ps

module mem_wb_stage_tb import mem_pkg::*; ();

    localparam int addr_bits  = 6;
    localparam int max_cycles = 2000;   // 6 tests, each well under 150 cycles
    localparam int num_tests  = 6;

    logic            clk = 1'b0;
    logic            rst;
    result_src_e     result_src;
    mem_mode_e       mem_mode;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] write_data;
    logic            we;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] result;
    logic            misaligned;

    logic [15:0] lfsr = 16'd8445;
    int          cycles = 0;
    int          errs_seen = 0;
    int          tests_failed = 0;
    int          checks_failed = 0;

    always #5 clk = ~clk;

    mem_wb_stage #(
        .addr_bits (addr_bits)
    ) i_mem_wb_stage (
        .clk        (clk),
        .rst        (rst),
        .result_src (result_src),
        .mem_mode   (mem_mode),
        .alu_result (alu_result),
        .write_data (write_data),
        .we         (we),
        .pc_plus4   (pc_plus4),
        .imm_ext    (imm_ext),
        .result     (result),
        .misaligned (misaligned)
    );

    bind mem_wb_stage mem_wb_stage_properties #(.addr_bits(addr_bits)) i_props (
        .clk        (clk),
        .rst        (rst),
        .result_src (result_src),
        .mem_mode   (mem_mode),
        .alu_result (alu_result),
        .write_data (write_data),
        .we         (we),
        .pc_plus4   (pc_plus4),
        .imm_ext    (imm_ext),
        .result     (result),
        .misaligned (misaligned)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic store(input mem_mode_e mode, input logic [31:0] addr,
                         input logic [31:0] data);
        @(posedge clk);
        we         <= 1'b1;
        mem_mode   <= mode;
        alu_result <= addr;
        write_data <= data;
        result_src <= res_alu;
    endtask

    task automatic load(input mem_mode_e mode, input logic [31:0] addr);
        @(posedge clk);
        we         <= 1'b0;
        mem_mode   <= mode;
        alu_result <= addr;
        result_src <= res_mem;
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(posedge clk);
        we         <= 1'b0;
        mem_mode   <= mode_none;
        result_src <= res_alu;
        errs = i_mem_wb_stage.i_props.err_count - errs_seen;
        errs_seen = errs_seen + errs;
        checks_failed = checks_failed + errs;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s finished with %0d check failures", name, errs);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] tmp;
        rst        <= 1'b1;
        we         <= 1'b0;
        mem_mode   <= mode_none;
        result_src <= res_alu;
        alu_result <= '0;
        write_data <= '0;
        pc_plus4   <= '0;
        imm_ext    <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // every source code, 4..7 unused
        for (int s = 0; s < 8; s++) begin
            @(posedge clk);
            random_bits(32, tmp);
            alu_result <= tmp;
            random_bits(32, tmp);
            pc_plus4 <= tmp;
            random_bits(32, tmp);
            imm_ext <= tmp;
            result_src <= result_src_e'(s[2:0]);
        end
        finish_test("result_mux");

        for (int i = 0; i < 8; i++) begin
            random_bits(32, addr);
            addr[1:0] = 2'b00;
            random_bits(32, data);
            store(mode_word, addr, data);
            load(mode_word, addr);
        end
        finish_test("word_store_load");

        random_bits(32, addr);
        addr[1:0] = 2'b00;
        random_bits(32, data);
        store(mode_word, addr, data);
        for (int k = 0; k < 4; k++) begin
            random_bits(32, data);
            store(mode_byte, {addr[31:2], k[1:0]}, data);
            load(mode_word, addr);
        end
        for (int k = 0; k < 2; k++) begin
            random_bits(32, data);
            store(mode_half, {addr[31:2], k[0], 1'b0}, data);
            load(mode_word, addr);
        end
        finish_test("lane_merge");

        for (int w = 0; w < 2; w++) begin
            random_bits(32, addr);
            addr[1:0] = 2'b00;
            random_bits(32, data);
            store(mode_word, addr, data | 32'h8080_8080);   // top bit set in each byte
            for (int k = 0; k < 4; k++) begin
                load(mode_byte, {addr[31:2], k[1:0]});
                load(mode_byte_u, {addr[31:2], k[1:0]});
            end
            for (int k = 0; k < 2; k++) begin
                load(mode_half, {addr[31:2], k[0], 1'b0});
                load(mode_half_u, {addr[31:2], k[0], 1'b0});
            end
        end
        finish_test("load_extend");

        random_bits(32, addr);
        addr[1:0] = 2'b00;
        random_bits(32, data);
        store(mode_word, addr, data);
        load(mode_word, addr);
        for (int k = 1; k < 4; k++) begin
            store(mode_word, {addr[31:2], k[1:0]}, ~data);
            load(mode_word, {addr[31:2], k[1:0]});
        end
        for (int k = 1; k < 4; k += 2) begin
            store(mode_half, {addr[31:2], k[1:0]}, ~data);
            load(mode_half, {addr[31:2], k[1:0]});
            load(mode_half_u, {addr[31:2], k[1:0]});
        end
        load(mode_word, addr);
        finish_test("misaligned");

        random_bits(32, addr);
        addr[1:0] = 2'b00;
        random_bits(32, data);
        store(mode_word, addr, data);
        store(mode_word, addr, ~data);
        rst <= 1'b1;
        store(mode_byte, addr, ~data);
        load(mode_word, addr);
        rst <= 1'b0;
        load(mode_word, addr);
        finish_test("store_in_reset");

        $display("summary: %0d tests, %0d failed, %0d check failures",
                 num_tests, tests_failed, checks_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mem_wb_stage.f
common/mem_pkg.sv
lsu/access_decode.sv
lsu/load_extend.sv
data_mem/data_ram.sv
design/mem_wb_stage.sv
testbench/mem_wb_stage_properties.sv
testbench/mem_wb_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run; the run passes only if the pass line shows up in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_wb_stage_tb \
    -f mem_wb_stage.f -o mem_wb_stage_sim &&
sim_out=$(./obj_dir/mem_wb_stage_sim +verilator+error+limit+10000) ;
printf '%s\n' "$sim_out" ;
printf '%s\n' "$sim_out" | grep -qx "All tests passed" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed" ; exit 1 ; }
